// ==== hw/exec_pkg.sv ====
/* Execute slice shared definitions
   Data and register index widths, ALU opcodes, issue and completion packets */
package exec_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // Machine word
    localparam int XLEN = 32;

    // Physical register index, caps the file at 64 entries
    localparam int PREG_IDX_W = 6;

    // Shift amount taken from the low bits of source 2
    localparam int SHAMT_W = 5;

    // Operand half used by the multiplier partial products
    localparam int HALF_W = XLEN / 2;

    typedef logic [XLEN-1:0]       data_t;
    typedef logic [PREG_IDX_W-1:0] preg_idx_t;

    ////////////////////////////////////////////////////////////
    // ALU operations
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4,
        ALU_SLL = 3'd5,
        ALU_SRL = 3'd6,
        ALU_SLT = 3'd7   // signed less-than
    } alu_op_t;

    ////////////////////////////////////////////////////////////
    // Packets
    ////////////////////////////////////////////////////////////

    // One issued micro-op
    // Multiplier ignores op
    typedef struct packed {
        logic      valid;
        preg_idx_t dest;
        preg_idx_t src1;
        preg_idx_t src2;
        alu_op_t   op;
    } issue_pkt_t;

    // One completion broadcast
    // Also the request format units present to the bus
    typedef struct packed {
        logic      valid;
        preg_idx_t dest;
        data_t     data;
    } cdb_pkt_t;

endpackage

// ==== hw/regfile.sv ====
/* Physical register file
   Combinational issue and retire reads, writes from every valid completion port */
`timescale 1ns/1ps

module regfile #(
    parameter int NUM_PREG = 64,
    parameter int NUM_ALU  = 2,
    parameter int NUM_CDB  = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,

    // Issue side reads
    input  exec_pkg::preg_idx_t [NUM_ALU-1:0]    alu_src1,
    input  exec_pkg::preg_idx_t [NUM_ALU-1:0]    alu_src2,
    input  exec_pkg::preg_idx_t                  mult_src1,
    input  exec_pkg::preg_idx_t                  mult_src2,

    // Commit side read
    input  exec_pkg::preg_idx_t                  retire_preg,

    // Completion broadcasts
    input  exec_pkg::cdb_pkt_t  [NUM_CDB-1:0]    cdb,

    output exec_pkg::data_t     [NUM_ALU-1:0]    alu_data1,
    output exec_pkg::data_t     [NUM_ALU-1:0]    alu_data2,
    output exec_pkg::data_t                      mult_data1,
    output exec_pkg::data_t                      mult_data2,
    output exec_pkg::data_t                      retire_data
);
    import exec_pkg::*;

    // Storage
    data_t [NUM_PREG-1:0] regs;

    ////////////////////////////////////////////////////////////
    // Read ports
    ////////////////////////////////////////////////////////////

    // Two operands per ALU lane
    for (genvar i = 0; i < NUM_ALU; i++) begin : g_alu_rd
        assign alu_data1[i] = regs[alu_src1[i]];
        assign alu_data2[i] = regs[alu_src2[i]];
    end

    // Multiplier operands
    assign mult_data1 = regs[mult_src1];
    assign mult_data2 = regs[mult_src2];

    // Committed value for the retire stage
    assign retire_data = regs[retire_preg];

    ////////////////////////////////////////////////////////////
    // Write ports
    ////////////////////////////////////////////////////////////

    // Register 0 never written so it always reads zero
    always_ff @(posedge clock) begin
        if (reset) begin
            regs <= '0;
        end else begin
            for (int p = 0; p < NUM_CDB; p++) begin
                if (cdb[p].valid && (cdb[p].dest != '0)) begin
                    regs[cdb[p].dest] <= cdb[p].data;
                end
            end
        end
    end

    // Completion bus and rename logic never target one register twice
    for (genvar a = 0; a < NUM_CDB; a++) begin : g_chk_a
        for (genvar b = a + 1; b < NUM_CDB; b++) begin : g_chk_b
            a_unique_dest: assert property (
                @(posedge clock) disable iff (reset)
                !(cdb[a].valid && cdb[b].valid &&
                  (cdb[a].dest != '0) && (cdb[a].dest == cdb[b].dest))
            ) else $error("regfile: ports %0d and %0d write preg %0d", a, b, cdb[a].dest);
        end
    end

endmodule

// ==== hw/alu_unit.sv ====
/* Integer ALU lanes
   Single-cycle compute into a per-lane hold register released by a bus grant */
`timescale 1ns/1ps

module alu_unit #(
    parameter int NUM_ALU = 2
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  exec_pkg::issue_pkt_t [NUM_ALU-1:0]   issue,
    input  exec_pkg::data_t      [NUM_ALU-1:0]   src1_data,
    input  exec_pkg::data_t      [NUM_ALU-1:0]   src2_data,
    input  logic                 [NUM_ALU-1:0]   grant,
    output exec_pkg::cdb_pkt_t   [NUM_ALU-1:0]   result,
    output logic                 [NUM_ALU-1:0]   busy
);
    import exec_pkg::*;

    // Result of one operation
    function automatic data_t alu_compute(input alu_op_t op, input data_t a, input data_t b);
        logic [SHAMT_W-1:0] shamt;
        shamt = b[SHAMT_W-1:0];
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a - b;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << shamt;
            ALU_SRL: return a >> shamt;
            ALU_SLT: return data_t'($signed(a) < $signed(b));
            default: return '0;
        endcase
    endfunction

    ////////////////////////////////////////////////////////////
    // Lanes
    ////////////////////////////////////////////////////////////

    for (genvar i = 0; i < NUM_ALU; i++) begin : g_lane
        logic      res_valid;
        preg_idx_t res_dest;
        data_t     res_data;

        // New issue overwrites a result granted this same cycle
        always_ff @(posedge clock) begin
            if (reset) begin
                res_valid <= 1'b0;
            end else if (issue[i].valid) begin
                res_valid <= 1'b1;
            end else if (grant[i]) begin
                res_valid <= 1'b0;
            end
        end

        // Payload
        always_ff @(posedge clock) begin
            if (issue[i].valid) begin
                res_dest <= issue[i].dest;
                res_data <= alu_compute(issue[i].op, src1_data[i], src2_data[i]);
            end
        end

        assign result[i] = cdb_pkt_t'{valid: res_valid, dest: res_dest, data: res_data};

        // Stall while a result waits for a port
        assign busy[i] = res_valid && !grant[i];

        // Issue stage must honor busy
        a_no_issue_busy: assert property (
            @(posedge clock) disable iff (reset)
            issue[i].valid |-> !busy[i]
        ) else $error("alu_unit: issue on busy lane %0d", i);
    end

endmodule

// ==== hw/mult_unit.sv ====
/* Pipelined multiplier
   Low 32 bits of the product, one new operation accepted every cycle */
`timescale 1ns/1ps

module mult_unit #(
    parameter int MULT_STAGES = 3
) (
    input  logic                  clock,
    input  logic                  reset,
    input  exec_pkg::issue_pkt_t  issue,
    input  exec_pkg::data_t       src1_data,
    input  exec_pkg::data_t       src2_data,
    output exec_pkg::cdb_pkt_t    result
);
    import exec_pkg::*;

    ////////////////////////////////////////////////////////////
    // Stage 1 partial products
    ////////////////////////////////////////////////////////////

    logic               s1_valid;
    preg_idx_t          s1_dest;
    logic [XLEN-1:0]    s1_ll;
    // Cross terms only matter in their low half
    logic [HALF_W-1:0]  s1_lh;
    logic [HALF_W-1:0]  s1_hl;

    // Stages 2 up to MULT_STAGES
    logic [MULT_STAGES:2] pv;
    preg_idx_t            pd [MULT_STAGES:2];
    data_t                pdata [MULT_STAGES:2];

    always_ff @(posedge clock) begin
        if (reset) begin
            s1_valid <= 1'b0;
            pv[2]    <= 1'b0;
        end else begin
            s1_valid <= issue.valid;
            pv[2]    <= s1_valid;
        end
    end

    always_ff @(posedge clock) begin
        s1_dest <= issue.dest;
        s1_ll   <= XLEN'(src1_data[HALF_W-1:0]) * XLEN'(src2_data[HALF_W-1:0]);
        s1_lh   <= src1_data[HALF_W-1:0] * src2_data[XLEN-1:HALF_W];
        s1_hl   <= src1_data[XLEN-1:HALF_W] * src2_data[HALF_W-1:0];
        // Stage 2 sum of the partial products
        pd[2]    <= s1_dest;
        pdata[2] <= s1_ll + {s1_lh + s1_hl, {HALF_W{1'b0}}};
    end

    // Extra delay stages
    for (genvar k = 3; k <= MULT_STAGES; k++) begin : g_delay
        always_ff @(posedge clock) begin
            if (reset) begin
                pv[k] <= 1'b0;
            end else begin
                pv[k] <= pv[k-1];
            end
        end

        always_ff @(posedge clock) begin
            pd[k]    <= pd[k-1];
            pdata[k] <= pdata[k-1];
        end
    end

    assign result = cdb_pkt_t'{valid: pv[MULT_STAGES], dest: pd[MULT_STAGES],
                               data: pdata[MULT_STAGES]};

    // Needs one stage for products and one for the sum
    initial begin
        a_depth: assert (MULT_STAGES >= 2)
            else $error("mult_unit: MULT_STAGES %0d below 2", MULT_STAGES);
    end

endmodule

// ==== hw/complete_bus.sv ====
/* Completion bus arbiter
   Multiplier on port 0, ALU lanes fill the remaining ports in lane order */
`timescale 1ns/1ps

module complete_bus #(
    parameter int NUM_ALU = 2,
    parameter int NUM_CDB = 2
) (
    // Only used to sample the check
    input  logic                                clock,
    input  logic                                reset,

    input  exec_pkg::cdb_pkt_t                  mult_result,
    input  exec_pkg::cdb_pkt_t [NUM_ALU-1:0]    alu_result,
    output logic               [NUM_ALU-1:0]    alu_grant,
    output exec_pkg::cdb_pkt_t [NUM_CDB-1:0]    cdb
);
    import exec_pkg::*;

    // Ports left for the ALU lanes
    int free_ports;

    assign free_ports = NUM_CDB - (mult_result.valid ? 1 : 0);

    ////////////////////////////////////////////////////////////
    // Port assignment
    ////////////////////////////////////////////////////////////

    always_comb begin
        int port;
        port      = 0;
        cdb       = '0;
        alu_grant = '0;

        // Multiplier cannot stall so it is never refused
        if (mult_result.valid) begin
            cdb[0] = mult_result;
            port   = 1;
        end

        // Lower lane wins
        for (int i = 0; i < NUM_ALU; i++) begin
            if (alu_result[i].valid && (port < NUM_CDB)) begin
                cdb[port]    = alu_result[i];
                alu_grant[i] = 1'b1;
                port         = port + 1;
            end
        end
    end

    // Grants bounded by what the multiplier leaves
    a_grant_count: assert property (
        @(posedge clock) disable iff (reset)
        $countones(alu_grant) <= free_ports
    ) else $error("complete_bus: %0d grants for %0d free ports",
                  $countones(alu_grant), free_ports);

endmodule

// ==== hw/exec_core.sv ====
/* Execute and writeback slice top
   Register file, ALU lanes and multiplier joined through the completion bus */
`timescale 1ns/1ps

module exec_core #(
    parameter int NUM_PREG    = 64,
    parameter int NUM_ALU     = 2,
    parameter int NUM_CDB     = 2,
    parameter int MULT_STAGES = 3
) (
    input  logic                                 clock,
    input  logic                                 reset,
    input  exec_pkg::issue_pkt_t [NUM_ALU-1:0]   alu_issue,
    input  exec_pkg::issue_pkt_t                 mult_issue,
    input  exec_pkg::preg_idx_t                  retire_preg,
    output logic                 [NUM_ALU-1:0]   alu_busy,
    output exec_pkg::cdb_pkt_t   [NUM_CDB-1:0]   cdb,
    output exec_pkg::data_t                      retire_data
);
    import exec_pkg::*;

    // Operand reads
    preg_idx_t [NUM_ALU-1:0] alu_src1;
    preg_idx_t [NUM_ALU-1:0] alu_src2;
    data_t     [NUM_ALU-1:0] alu_data1;
    data_t     [NUM_ALU-1:0] alu_data2;
    data_t                   mult_data1;
    data_t                   mult_data2;

    // Unit results and arbitration
    cdb_pkt_t  [NUM_ALU-1:0] alu_result;
    cdb_pkt_t                mult_result;
    logic      [NUM_ALU-1:0] alu_grant;

    for (genvar i = 0; i < NUM_ALU; i++) begin : g_src
        assign alu_src1[i] = alu_issue[i].src1;
        assign alu_src2[i] = alu_issue[i].src2;
    end

    regfile #(.NUM_PREG(NUM_PREG), .NUM_ALU(NUM_ALU), .NUM_CDB(NUM_CDB)) i_regfile (
        .clock, .reset,
        .alu_src1, .alu_src2,
        .mult_src1(mult_issue.src1), .mult_src2(mult_issue.src2),
        .retire_preg, .cdb,
        .alu_data1, .alu_data2, .mult_data1, .mult_data2, .retire_data
    );

    alu_unit #(.NUM_ALU(NUM_ALU)) i_alu_unit (
        .clock, .reset,
        .issue(alu_issue), .src1_data(alu_data1), .src2_data(alu_data2),
        .grant(alu_grant), .result(alu_result), .busy(alu_busy)
    );

    mult_unit #(.MULT_STAGES(MULT_STAGES)) i_mult_unit (
        .clock, .reset,
        .issue(mult_issue), .src1_data(mult_data1), .src2_data(mult_data2),
        .result(mult_result)
    );

    complete_bus #(.NUM_ALU(NUM_ALU), .NUM_CDB(NUM_CDB)) i_complete_bus (
        .clock, .reset,
        .mult_result, .alu_result, .alu_grant, .cdb
    );

endmodule

// ==== tests/exec_core_tb.sv ====
/* Execute slice testbench
   Directed and random issue checked against a shadow register model */
`timescale 1ns/1ps

module exec_core_tb;
    import exec_pkg::*;

    localparam int NUM_PREG    = 64;
    localparam int NUM_ALU     = 2;
    localparam int NUM_CDB     = 2;
    localparam int MULT_STAGES = 3;
    localparam int PERIOD      = 10;
    localparam int TIMEOUT     = 40;
    localparam int NUM_SEEDS   = 8;

    logic                     clock;
    logic                     reset;
    issue_pkt_t [NUM_ALU-1:0] alu_issue;
    issue_pkt_t               mult_issue;
    preg_idx_t                retire_preg;
    logic       [NUM_ALU-1:0] alu_busy;
    cdb_pkt_t   [NUM_CDB-1:0] cdb;
    data_t                    retire_data;

    // Model state per physical register
    data_t shadow      [NUM_PREG];
    logic  written     [NUM_PREG];
    logic  pending     [NUM_PREG];
    data_t pending_val [NUM_PREG];
    time   issue_time  [NUM_PREG];
    time   done_time   [NUM_PREG];
    int    done_port   [NUM_PREG];

    int error_count;
    int check_count;
    int test_errors;

    exec_core #(
        .NUM_PREG(NUM_PREG), .NUM_ALU(NUM_ALU), .NUM_CDB(NUM_CDB), .MULT_STAGES(MULT_STAGES)
    ) i_exec_core (
        .clock, .reset, .alu_issue, .mult_issue, .retire_preg,
        .alu_busy, .cdb, .retire_data
    );

    initial begin
        clock = 1'b0;
        forever #(PERIOD / 2) clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Reference model
    ////////////////////////////////////////////////////////////

    function automatic data_t expected_result(input logic is_mult, input alu_op_t op,
                                              input data_t a, input data_t b);
        logic [2*XLEN-1:0] product;
        int                amount;
        product = {{XLEN{1'b0}}, a} * {{XLEN{1'b0}}, b};
        // Shift amount is source 2 modulo the word width
        amount  = int'(b % 32);
        if (is_mult) begin
            return product[XLEN-1:0];
        end
        case (op)
            ALU_ADD: return a + b;
            ALU_SUB: return a + ~b + 1;
            ALU_AND: return a & b;
            ALU_OR:  return a | b;
            ALU_XOR: return a ^ b;
            ALU_SLL: return a << amount;
            ALU_SRL: return a >> amount;
            default: begin
                // Differing signs decide it, else plain magnitude
                if (a[XLEN-1] != b[XLEN-1]) begin
                    return data_t'(a[XLEN-1]);
                end
                return data_t'(a < b);
            end
        endcase
    endfunction

    task automatic report_error(input string msg);
        error_count++;
        $display("ERROR %0t ns: %s", $time, msg);
    endtask

    // Compare every broadcast with the expectation of its destination
    always @(negedge clock) begin
        preg_idx_t d;
        if (!reset) begin
            for (int p = 0; p < NUM_CDB; p++) begin
                if (cdb[p].valid) begin
                    d = cdb[p].dest;
                    check_count++;
                    if (!pending[d]) begin
                        error_count++;
                        $display("Completion on port %0d for preg %0d at %0t ns was never issued",
                                 p, d, $time);
                    end else if (cdb[p].data !== pending_val[d]) begin
                        report_error($sformatf("preg %0d on port %0d is %h, expected %h",
                                               d, p, cdb[p].data, pending_val[d]));
                    end
                    pending[d]   = 1'b0;
                    done_time[d] = $time;
                    done_port[d] = p;
                    // Register 0 keeps its zero
                    if (d != '0) begin
                        shadow[d]  = pending_val[d];
                        written[d] = 1'b1;
                    end
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////////////////////////

    task automatic next_cycle();
        @(posedge clock);
        alu_issue  <= '0;
        mult_issue <= '0;
    endtask

    task automatic issue_alu(input int lane, input preg_idx_t dest, input preg_idx_t src1,
                             input preg_idx_t src2, input alu_op_t op);
        pending[dest]     = 1'b1;
        pending_val[dest] = expected_result(1'b0, op, shadow[src1], shadow[src2]);
        issue_time[dest]  = $time;
        alu_issue[lane]  <= issue_pkt_t'{valid: 1'b1, dest: dest, src1: src1, src2: src2, op: op};
    endtask

    task automatic issue_mult(input preg_idx_t dest, input preg_idx_t src1,
                              input preg_idx_t src2);
        pending[dest]     = 1'b1;
        pending_val[dest] = expected_result(1'b1, ALU_ADD, shadow[src1], shadow[src2]);
        issue_time[dest]  = $time;
        mult_issue       <= issue_pkt_t'{valid: 1'b1, dest: dest, src1: src1, src2: src2,
                                          op: ALU_ADD};
    endtask

    // Committed register with no write in flight
    function automatic preg_idx_t pick_source();
        preg_idx_t idx;
        for (int tries = 0; tries < 32; tries++) begin
            idx = preg_idx_t'($urandom_range(NUM_PREG - 1, 0));
            if (written[idx] && !pending[idx]) begin
                return idx;
            end
        end
        return '0;
    endfunction

    // Zero means no free destination
    function automatic preg_idx_t pick_dest();
        preg_idx_t idx;
        for (int tries = 0; tries < 32; tries++) begin
            idx = preg_idx_t'($urandom_range(NUM_PREG - 1, 1));
            if (!pending[idx]) begin
                return idx;
            end
        end
        return '0;
    endfunction

    function automatic preg_idx_t nonzero_source();
        for (int k = 1; k < NUM_PREG; k++) begin
            if (written[k] && !pending[k] && (shadow[k] != '0)) begin
                return preg_idx_t'(k);
            end
        end
        return preg_idx_t'(1);
    endfunction

    function automatic int outstanding();
        int n;
        n = 0;
        for (int k = 0; k < NUM_PREG; k++) begin
            if (pending[k]) begin
                n++;
            end
        end
        return n;
    endfunction

    task automatic wait_done(input preg_idx_t dest);
        int waited;
        waited = 0;
        while (pending[dest] && (waited < TIMEOUT)) begin
            next_cycle();
            waited++;
        end
        if (pending[dest]) begin
            error_count++;
            $display("Timed out waiting for preg %0d to complete", dest);
            pending[dest] = 1'b0;
        end
    endtask

    // Completion seen at the falling edge inside the result cycle
    task automatic check_latency(input preg_idx_t dest, input int cycles);
        check_count++;
        if (done_time[dest] != issue_time[dest] + time'(cycles * PERIOD + PERIOD / 2)) begin
            report_error($sformatf("preg %0d done at %0t ns, expected %0d cycles after issue",
                                   dest, done_time[dest], cycles));
        end
    endtask

    task automatic check_retire(input preg_idx_t idx, input data_t expected);
        next_cycle();
        retire_preg <= idx;
        @(negedge clock);
        check_count++;
        if (retire_data !== expected) begin
            report_error($sformatf("retire preg %0d reads %h, expected %h",
                                   idx, retire_data, expected));
        end
    endtask

    task automatic end_test(input string name);
        $display("%s done, %0d errors", name, error_count - test_errors);
        test_errors = error_count;
    endtask

    // Random seed values written straight into the first few registers
    task automatic load_seeds();
        data_t v;
        @(negedge clock);
        for (int k = 1; k <= NUM_SEEDS; k++) begin
            v = $urandom();
            i_exec_core.i_regfile.regs[k] = v;
            shadow[k]  = v;
            written[k] = 1'b1;
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic reset_checks();
        repeat (3) begin
            @(negedge clock);
            for (int p = 0; p < NUM_CDB; p++) begin
                check_count++;
                if (cdb[p].valid !== 1'b0) begin
                    report_error($sformatf("cdb port %0d valid is %b after reset",
                                           p, cdb[p].valid));
                end
            end
            check_count++;
            if (alu_busy !== '0) begin
                report_error($sformatf("alu_busy is %b after reset", alu_busy));
            end
        end
        repeat (4) check_retire(preg_idx_t'($urandom_range(NUM_PREG - 1, 0)), '0);
    endtask

    // One lane at a time so every result lands one cycle after issue
    task automatic alu_op_sweep();
        preg_idx_t src1, src2, dest;
        for (int lane = 0; lane < NUM_ALU; lane++) begin
            for (int op = 0; op < 8; op++) begin
                repeat (2) begin
                    src1 = pick_source();
                    src2 = pick_source();
                    dest = pick_dest();
                    next_cycle();
                    issue_alu(lane, dest, src1, src2, alu_op_t'(op));
                    wait_done(dest);
                    check_latency(dest, 1);
                    check_retire(dest, pending_val[dest]);
                end
            end
        end
    endtask

    task automatic mult_latency();
        preg_idx_t dest [4];
        dest[0] = pick_dest();
        next_cycle();
        issue_mult(dest[0], pick_source(), pick_source());
        wait_done(dest[0]);
        check_latency(dest[0], MULT_STAGES);
        check_retire(dest[0], pending_val[dest[0]]);
        // Back-to-back stream
        for (int k = 0; k < 4; k++) begin
            dest[k] = pick_dest();
            next_cycle();
            issue_mult(dest[k], pick_source(), pick_source());
        end
        for (int k = 0; k < 4; k++) begin
            wait_done(dest[k]);
            check_latency(dest[k], MULT_STAGES);
        end
        for (int k = 1; k < 4; k++) begin
            check_count++;
            if (done_time[dest[k]] != done_time[dest[k-1]] + time'(PERIOD)) begin
                report_error($sformatf("multiply %0d not one cycle after multiply %0d", k, k - 1));
            end
        end
        for (int k = 0; k < 4; k++) begin
            check_retire(dest[k], pending_val[dest[k]]);
        end
    endtask

    // Multiplier issued early so all three results meet on the bus
    task automatic port_contention();
        preg_idx_t dm, d0, d1;
        dm = pick_dest();
        next_cycle();
        issue_mult(dm, pick_source(), pick_source());
        repeat (MULT_STAGES - 1) next_cycle();
        d0 = pick_dest();
        issue_alu(0, d0, pick_source(), pick_source(), ALU_ADD);
        d1 = pick_dest();
        issue_alu(1, d1, pick_source(), pick_source(), ALU_XOR);
        next_cycle();
        @(negedge clock);
        check_count++;
        if (alu_busy !== 2'b10) begin
            report_error($sformatf("alu_busy is %b under contention, expected 10", alu_busy));
        end
        wait_done(dm);
        wait_done(d0);
        wait_done(d1);
        check_count++;
        if ((done_port[dm] != 0) || (done_port[d0] != 1)) begin
            report_error($sformatf("multiply on port %0d, lane 0 on port %0d",
                                   done_port[dm], done_port[d0]));
        end
        check_latency(dm, MULT_STAGES);
        check_latency(d0, 1);
        check_latency(d1, 2);
        check_retire(dm, pending_val[dm]);
        check_retire(d0, pending_val[d0]);
        check_retire(d1, pending_val[d1]);
    endtask

    task automatic zero_dest();
        preg_idx_t src, dest;
        src = nonzero_source();
        // Broadcast carries the value, the file drops it
        next_cycle();
        issue_alu(0, '0, src, '0, ALU_ADD);
        wait_done('0);
        check_retire('0, '0);
        next_cycle();
        issue_mult('0, src, src);
        wait_done('0);
        check_retire('0, '0);
        // Register 0 as a source
        dest = pick_dest();
        next_cycle();
        issue_alu(1, dest, src, '0, ALU_OR);
        wait_done(dest);
        check_retire(dest, pending_val[dest]);
        dest = pick_dest();
        next_cycle();
        issue_mult(dest, src, '0);
        wait_done(dest);
        check_retire(dest, pending_val[dest]);
    endtask

    task automatic random_mix(input int total);
        int                 issued;
        int                 cycles;
        logic [NUM_ALU-1:0] busy_seen;
        logic [NUM_ALU-1:0] last_issue;
        logic [NUM_ALU-1:0] this_issue;
        preg_idx_t          dest;
        issued     = 0;
        cycles     = 0;
        last_issue = '0;
        while ((issued < total) && (cycles < total * 10)) begin
            @(negedge clock);
            busy_seen = alu_busy;
            next_cycle();
            this_issue = '0;
            // A lane issued last cycle may still lose arbitration this cycle
            for (int lane = 0; lane < NUM_ALU; lane++) begin
                dest = pick_dest();
                if (!busy_seen[lane] && !last_issue[lane] && (dest != '0) &&
                    ($urandom_range(1, 0) == 1)) begin
                    issue_alu(lane, dest, pick_source(), pick_source(),
                              alu_op_t'($urandom_range(7, 0)));
                    this_issue[lane] = 1'b1;
                    issued++;
                end
            end
            dest = pick_dest();
            if ((dest != '0) && ($urandom_range(2, 0) == 0)) begin
                issue_mult(dest, pick_source(), pick_source());
                issued++;
            end
            last_issue = this_issue;
            cycles++;
        end
        // Drain what is still in flight
        cycles = 0;
        while ((outstanding() != 0) && (cycles < TIMEOUT)) begin
            next_cycle();
            cycles++;
        end
        if (outstanding() != 0) begin
            error_count++;
            $display("%0d expectations left outstanding after the random run", outstanding());
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        void'($urandom(93168));
        reset       = 1'b1;
        alu_issue   = '0;
        mult_issue  = '0;
        retire_preg = '0;
        error_count = 0;
        check_count = 0;
        test_errors = 0;
        for (int k = 0; k < NUM_PREG; k++) begin
            shadow[k]      = '0;
            written[k]     = (k == 0);
            pending[k]     = 1'b0;
            pending_val[k] = '0;
        end
        repeat (5) @(posedge clock);
        reset <= 1'b0;

        reset_checks();
        end_test("Test 1 reset state");
        load_seeds();
        alu_op_sweep();
        end_test("Test 2 ALU operations");
        mult_latency();
        end_test("Test 3 multiplier latency");
        port_contention();
        end_test("Test 4 port contention");
        zero_dest();
        end_test("Test 5 register 0");
        random_mix(200);
        end_test("Test 6 random mix");

        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== vlog.f ====
hw/exec_pkg.sv
hw/regfile.sv
hw/alu_unit.sv
hw/mult_unit.sv
hw/complete_bus.sv
hw/exec_core.sv
tests/exec_core_tb.sv

// ==== Makefile ====
# Verilator build and run for the execute slice

VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = exec_core_tb
FILELIST  = vlog.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# Pass or fail is taken from the log
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qF '*** PASSED ***' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
